/* can_bridge_top.f */
+incdir+hdl
hdl/can_msg_pkg.sv
hdl/can_reg_pkg.sv
hdl/can_word_fmt.sv
hdl/can_tx_seq.sv
hdl/can_init_seq.sv
hdl/can_reg_arbiter.sv
hdl/can_bridge_top.sv
dv/tb_clk_gen.sv
dv/can_bridge_props.sv
dv/can_bridge_tb.sv

/* Makefile */
# Verilator flow for the CAN register-write bridge

VERILATOR  ?= verilator
FILELIST   ?= can_bridge_top.f
TB_TOP     ?= can_bridge_tb
RTL_TOP    ?= can_bridge_top
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --timing --assert
LINT_FLAGS ?= -Wall --timing

SIM_BIN = $(OBJ_DIR)/V$(TB_TOP)

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TB_TOP) -Mdir $(OBJ_DIR)

# Exit status of the simulation binary is the pass/fail result
sim: build
	./$(SIM_BIN)

clean:
	rm -rf $(OBJ_DIR)

/* dv/can_bridge_tb.sv */
`timescale 1ns/1ps
`include "can_consts.svh"

module can_bridge_tb
  import can_msg_pkg::*;
();

  localparam int NUM_MSGS        = 40;
  localparam int WATCHDOG_CYCLES = NUM_MSGS * 20 + 100;

  typedef struct packed {
    logic [4:0]  addr;
    logic [15:0] data;
  } exp_word_t;

  logic        clock;
  logic        rst_n;
  logic        msg_valid;
  can_msg_t    msg;
  logic        reg_wr;
  logic [4:0]  reg_addr;
  logic [15:0] reg_wdata;
  logic        init_done;
  logic        tx_busy;
  logic        tx_done;

  exp_word_t exp_q[$];      // Words still owed by the DUT, in bus order
  int        done_count = 0;

  tb_clk_gen #(.PERIOD_NS(4)) u_clk_gen (.clock(clock));

  can_bridge_top i_can_bridge_top (
    .clock     (clock),
    .rst_n     (rst_n),
    .msg_valid (msg_valid),
    .msg       (msg),
    .reg_wr    (reg_wr),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata),
    .init_done (init_done),
    .tx_busy   (tx_busy),
    .tx_done   (tx_done)
  );

  bind can_reg_arbiter can_bridge_props u_props (
    .clock    (clock),
    .rst_n    (rst_n),
    .req      (req),
    .gnt      (gnt),
    .reg_wr   (reg_wr),
    .reg_addr (reg_addr)
  );

  task automatic stop_on_error(input string what);
    $display("%s", what);
    $display("** FAIL **");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  // Controller register word for one transmit address
  function automatic logic [15:0] expected_word(input logic [4:0] addr, input can_msg_t m);
    logic [15:0] w;
    case (addr)
      `REG_TRA_ID1:  w = {m.id, 5'b00000};
      `REG_TRA_D12:  w = {m.data_b[0], m.data_b[1]};
      `REG_TRA_D34:  w = {m.data_b[2], m.data_b[3]};
      `REG_TRA_D56:  w = {m.data_b[5], m.data_b[4]};  // Swapped pair
      `REG_TRA_D78:  w = {m.data_b[7], m.data_b[6]};
      `REG_TRA_CTRL: w = `TRA_CONTROL_VAL;
      default:       w = 16'h0000;
    endcase
    return w;
  endfunction

  function automatic logic [4:0] tx_addr(input int step);
    logic [4:0] a;
    case (step)
      0:       a = `REG_TRA_ID1;
      1:       a = `REG_TRA_D12;
      2:       a = `REG_TRA_D34;
      3:       a = `REG_TRA_D56;
      4:       a = `REG_TRA_D78;
      default: a = `REG_TRA_CTRL;
    endcase
    return a;
  endfunction

  function automatic logic is_tx_addr(input logic [4:0] addr);
    return addr inside {`REG_TRA_ID1, `REG_TRA_D12, `REG_TRA_D34,
                        `REG_TRA_D56, `REG_TRA_D78, `REG_TRA_CTRL};
  endfunction

  task automatic queue_init_words();
    exp_word_t e;
    e.addr = `REG_GEN;
    e.data = `GEN_DATA_VAL;
    exp_q.push_back(e);
    e.addr = `REG_IRQ;
    e.data = `RST_IRQ_VAL;
    exp_q.push_back(e);
  endtask

  task automatic queue_message(input can_msg_t m);
    exp_word_t e;
    for (int s = 0; s < 6; s++) begin
      e.addr = tx_addr(s);
      e.data = expected_word(e.addr, m);
      exp_q.push_back(e);
    end
  endtask

  task automatic random_message(output can_msg_t m);
    m.id = 11'($urandom);
    for (int b = 0; b < 8; b++) begin
      m.data_b[b] = 8'($urandom);
    end
  endtask

  task automatic check_idle(input string when);
    assert (!reg_wr && !tx_busy && !tx_done && !init_done)
      else stop_on_error({"outputs not idle ", when});
  endtask

  // Strobe one message and hold on until its control write
  task automatic send_message(input can_msg_t m);
    msg       = m;
    msg_valid = 1'b1;
    queue_message(m);
    @(negedge clock);
    msg_valid = 1'b0;
    while (!tx_done) begin
      assert (tx_busy) else stop_on_error("tx_busy low while a message is still pending");
      @(negedge clock);
    end
  endtask

  initial begin
    can_msg_t m;
    void'($urandom(15818));
    rst_n     = 1'b0;
    msg_valid = 1'b0;
    msg       = '0;
    queue_init_words();
    repeat (4) begin
      @(negedge clock);
      check_idle("during reset");
    end
    rst_n = 1'b1;
    @(negedge clock);
    check_idle("in the first cycle after reset");
    // First message lands while the init words are still pending
    for (int i = 0; i < NUM_MSGS; i++) begin
      random_message(m);
      send_message(m);
    end
    @(negedge clock);  // Compare process takes the last word
    if (exp_q.size() == 0 && done_count == NUM_MSGS) begin
      $display("** PASS **");
      $finish;
    end else begin
      stop_on_error($sformatf("run ended with %0d words unwritten and %0d of %0d messages done",
                              exp_q.size(), done_count, NUM_MSGS));
    end
  end

  // Bus outputs are registered, so mid-cycle sampling sees settled values
  always @(negedge clock) begin
    exp_word_t exp_e;
    if (rst_n) begin
      if (tx_done) begin
        assert (reg_wr && reg_addr == `REG_TRA_CTRL)
          else stop_on_error("tx_done pulsed without a control register write");
        done_count++;
      end
      if (reg_wr) begin
        assert (exp_q.size() > 0) else stop_on_error("register write with no word expected");
        exp_e = exp_q.pop_front();
        assert (reg_addr == exp_e.addr)
          else stop_on_error($sformatf("MISMATCH reg_addr expected 0x%02h got 0x%02h",
                                       exp_e.addr, reg_addr));
        assert (reg_wdata == exp_e.data)
          else stop_on_error($sformatf("MISMATCH reg_wdata expected 0x%04h got 0x%04h",
                                       exp_e.data, reg_wdata));
        if (reg_addr == `REG_GEN) begin
          assert (!init_done) else stop_on_error("init_done high before the IRQ write");
        end
        if (reg_addr == `REG_IRQ) begin
          assert (init_done) else stop_on_error("init_done not raised with the IRQ write");
        end
        if (is_tx_addr(reg_addr)) begin
          assert (init_done) else stop_on_error("transmit word written before init_done");
        end
        if (reg_addr == `REG_TRA_CTRL) begin
          assert (tx_done && !tx_busy)
            else stop_on_error("control write without tx_done, or tx_busy still high");
        end else if (is_tx_addr(reg_addr)) begin
          assert (tx_busy && !tx_done)
            else stop_on_error("transmit word written while tx_busy low or tx_done high");
        end
      end
    end
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clock);
    stop_on_error($sformatf("watchdog expired after %0d cycles with the run unfinished",
                            WATCHDOG_CYCLES));
  end

endmodule

/* dv/can_bridge_props.sv */
`timescale 1ns/1ps
`include "can_consts.svh"

module can_bridge_props (
  input logic                    clock,
  input logic                    rst_n,
  input logic [`REG_NUM_REQ-1:0] req,
  input logic [`REG_NUM_REQ-1:0] gnt,
  input logic                    reg_wr,
  input logic [4:0]              reg_addr
);

  // Fixed priority never hands out two grants
  one_grant: assert property (@(posedge clock) disable iff (!rst_n) $onehot0(gnt))
    else $error("arbiter raised more than one grant in a cycle");

  // Bus stays quiet while reset is held
  quiet_in_reset: assert property (@(posedge clock) !rst_n |=> !reg_wr)
    else $error("register write strobe seen during reset");

  known_addr: assert property (@(posedge clock) disable iff (!rst_n)
    reg_wr |-> reg_addr inside {`REG_TRA_ID1, `REG_TRA_D12, `REG_TRA_D34, `REG_TRA_D56,
                                `REG_TRA_D78, `REG_TRA_CTRL, `REG_GEN, `REG_IRQ})
    else $error("register write to an address outside the defined set");

  grant_needs_req: assert property (@(posedge clock) disable iff (!rst_n)
    (gnt & ~req) == '0)
    else $error("grant given to a requester that is not requesting");

endmodule

/* dv/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int PERIOD_NS = 4
) (
  output logic clock = 1'b0  // Starts low, so time zero has no edge
);

  initial begin
    forever #(PERIOD_NS / 2) clock = ~clock;  // First rising edge at half a period
  end

endmodule

/* hdl/can_bridge_top.sv */
`timescale 1ns/1ps
`include "can_consts.svh"

module can_bridge_top
  import can_msg_pkg::*;
  import can_reg_pkg::*;
(
  input  logic        clock,
  input  logic        rst_n,
  input  logic        msg_valid,
  input  can_msg_t    msg,
  output logic        reg_wr,
  output logic [4:0]  reg_addr,
  output logic [15:0] reg_wdata,
  output logic        init_done,
  output logic        tx_busy,
  output logic        tx_done
);

  logic [`REG_NUM_REQ-1:0] req;
  logic [`REG_NUM_REQ-1:0] gnt;
  reg_req_t                req_data [`REG_NUM_REQ];

  // Requester 0, highest priority
  can_init_seq u_init_seq (
    .clock     (clock),
    .rst_n     (rst_n),
    .gnt       (gnt[0]),
    .req       (req[0]),
    .req_data  (req_data[0]),
    .init_done (init_done)
  );

  // Requester 1
  can_tx_seq u_tx_seq (
    .clock     (clock),
    .rst_n     (rst_n),
    .msg_valid (msg_valid),
    .msg       (msg),
    .gnt       (gnt[1]),
    .req       (req[1]),
    .req_data  (req_data[1]),
    .tx_busy   (tx_busy),
    .tx_done   (tx_done)
  );

  can_reg_arbiter u_arbiter (
    .clock     (clock),
    .rst_n     (rst_n),
    .req       (req),
    .req_data  (req_data),
    .gnt       (gnt),
    .reg_wr    (reg_wr),
    .reg_addr  (reg_addr),
    .reg_wdata (reg_wdata)
  );

endmodule

/* hdl/can_reg_arbiter.sv */
`timescale 1ns/1ps
`include "can_consts.svh"

module can_reg_arbiter
  import can_reg_pkg::*;
(
  input  logic                    clock,
  input  logic                    rst_n,
  input  logic [`REG_NUM_REQ-1:0] req,
  input  reg_req_t                req_data [`REG_NUM_REQ],
  output logic [`REG_NUM_REQ-1:0] gnt,
  output logic                    reg_wr,
  output logic [4:0]              reg_addr,
  output logic [15:0]             reg_wdata
);

  reg_req_t sel;    // Winning request this cycle
  reg_req_t bus_q;  // Word on the controller bus
  logic     wr_q;

  // Lowest index wins, so the loop runs downward and the last hit sticks
  always_comb begin
    gnt = '0;
    sel = '0;
    for (int i = `REG_NUM_REQ - 1; i >= 0; i--) begin
      if (req[i]) begin
        gnt    = '0;
        gnt[i] = 1'b1;
        sel    = req_data[i];
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      wr_q <= 1'b0;
    end else begin
      wr_q <= |req;  // Any request is granted this cycle
    end
  end

  always_ff @(posedge clock) begin
    if (|req) bus_q <= sel;
  end

  assign reg_wr    = wr_q;
  assign reg_addr  = bus_q.addr;
  assign reg_wdata = bus_q.data.raw;

endmodule

/* hdl/can_init_seq.sv */
`timescale 1ns/1ps
`include "can_consts.svh"

module can_init_seq
  import can_reg_pkg::*;
(
  input  logic     clock,
  input  logic     rst_n,
  input  logic     gnt,
  output logic     req,
  output reg_req_t req_data,
  output logic     init_done
);

  logic armed_q;  // Set one cycle after reset release
  logic step_q;   // 0 for GEN, 1 for IRQ
  logic done_q;

  assign req = armed_q & ~done_q;

  always_comb begin
    if (step_q) begin
      req_data.addr     = `REG_IRQ;
      req_data.data.raw = `RST_IRQ_VAL;
    end else begin
      req_data.addr     = `REG_GEN;
      req_data.data.raw = `GEN_DATA_VAL;
    end
  end

  assign init_done = done_q;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      armed_q <= 1'b0;
      step_q  <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      armed_q <= 1'b1;
      if (req && gnt) begin
        if (step_q) begin
          done_q <= 1'b1;  // Held until the next reset
        end else begin
          step_q <= 1'b1;
        end
      end
    end
  end

endmodule

/* hdl/can_tx_seq.sv */
`timescale 1ns/1ps
`include "can_consts.svh"

module can_tx_seq
  import can_msg_pkg::*;
  import can_reg_pkg::*;
(
  input  logic     clock,
  input  logic     rst_n,
  input  logic     msg_valid,  // One-cycle strobe from host
  input  can_msg_t msg,
  input  logic     gnt,
  output logic     req,
  output reg_req_t req_data,
  output logic     tx_busy,
  output logic     tx_done
);

  localparam logic [2:0] LAST_STEP = 3'd5;  // CTRL is the sixth word

  logic       busy_q;
  logic       done_q;
  logic [2:0] step_q;     // Index into the fixed address order
  can_msg_t   msg_q;      // Latched message
  logic [4:0] cur_addr;
  reg_word_u  cur_word;

  // Fixed transmit order, CTRL last
  always_comb begin
    case (step_q)
      3'd0:    cur_addr = `REG_TRA_ID1;
      3'd1:    cur_addr = `REG_TRA_D12;
      3'd2:    cur_addr = `REG_TRA_D34;
      3'd3:    cur_addr = `REG_TRA_D56;
      3'd4:    cur_addr = `REG_TRA_D78;
      default: cur_addr = `REG_TRA_CTRL;
    endcase
  end

  can_word_fmt u_fmt (
    .addr (cur_addr),
    .msg  (msg_q),
    .word (cur_word)
  );

  assign req           = busy_q;
  assign req_data.addr = cur_addr;
  assign req_data.data = cur_word;
  assign tx_busy       = busy_q;
  assign tx_done       = done_q;

  always_ff @(posedge clock) begin
    if (!rst_n) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      step_q <= '0;
    end else begin
      done_q <= 1'b0;
      if (!busy_q) begin
        step_q <= '0;
        if (msg_valid) busy_q <= 1'b1;  // Strobe only looked at while idle
      end else if (gnt) begin
        if (step_q == LAST_STEP) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;  // Lines up with the CTRL write on the bus
          step_q <= '0;
        end else begin
          step_q <= step_q + 3'd1;
        end
      end
    end
  end

  always_ff @(posedge clock) begin
    if (!busy_q && msg_valid) msg_q <= msg;
  end

endmodule

/* hdl/can_word_fmt.sv */
`timescale 1ns/1ps
`include "can_consts.svh"

module can_word_fmt
  import can_msg_pkg::*;
  import can_reg_pkg::*;
(
  input  logic [4:0] addr,  // Register being written
  input  can_msg_t   msg,
  output reg_word_u  word
);

  always_comb begin
    word = '0;
    case (addr)
      `REG_TRA_ID1: begin
        word.id_v.id   = msg.id;
        word.id_v.zero = '0;
      end
      `REG_TRA_D12: begin
        word.pair_v.hi = msg.data_b[0];
        word.pair_v.lo = msg.data_b[1];
      end
      `REG_TRA_D34: begin
        word.pair_v.hi = msg.data_b[2];
        word.pair_v.lo = msg.data_b[3];
      end
      // The controller expects the last two pairs byte-swapped
      `REG_TRA_D56: begin
        word.pair_v.hi = msg.data_b[5];
        word.pair_v.lo = msg.data_b[4];
      end
      `REG_TRA_D78: begin
        word.pair_v.hi = msg.data_b[7];
        word.pair_v.lo = msg.data_b[6];
      end
      `REG_TRA_CTRL: begin
        word.raw = `TRA_CONTROL_VAL;  // Kicks off transmission
      end
      default: begin
        word.raw = '0;
      end
    endcase
  end

endmodule

/* hdl/can_reg_pkg.sv */
package can_reg_pkg;

  // Identifier register layout
  typedef struct packed {
    logic [10:0] id;    // Identifier in the upper bits
    logic [4:0]  zero;  // Unused low bits
  } id_view_t;

  // Data-pair register layout
  typedef struct packed {
    logic [7:0] hi;
    logic [7:0] lo;
  } pair_view_t;

  // One 16-bit controller register word
  typedef union packed {
    id_view_t   id_v;
    pair_view_t pair_v;
    logic [15:0] raw;  // What the bus carries
  } reg_word_u;

  // Single register write request
  typedef struct packed {
    logic [4:0] addr;
    reg_word_u  data;
  } reg_req_t;

endpackage

/* hdl/can_msg_pkg.sv */
package can_msg_pkg;

  // One transmit message as the host hands it over
  typedef struct packed {
    logic [10:0]     id;      // Standard 11-bit identifier
    logic [7:0][7:0] data_b;  // Payload bytes, data_b[0] is the first byte
  } can_msg_t;

endpackage

/* hdl/can_consts.svh */
`ifndef CAN_CONSTS_SVH
`define CAN_CONSTS_SVH

// Controller register addresses on the 5-bit write bus
`define REG_TRA_ID1   5'h0C  // Transmit identifier
`define REG_TRA_D12   5'h0A  // Transmit data bytes 1 and 2
`define REG_TRA_D34   5'h09  // Transmit data bytes 3 and 4
`define REG_TRA_D56   5'h08  // Transmit data bytes 5 and 6, swapped
`define REG_TRA_D78   5'h07  // Transmit data bytes 7 and 8, swapped
`define REG_TRA_CTRL  5'h0D  // Transmission control
`define REG_GEN       5'h0E  // General configuration
`define REG_IRQ       5'h12  // Interrupt reset

// Fixed register contents
`define TRA_CONTROL_VAL 16'h8008  // Start transmission
`define RST_IRQ_VAL     16'h8070  // Clear pending interrupts
`define GEN_DATA_VAL    16'h009C  // General setup word

// Requesters sharing the register write bus
`define REG_NUM_REQ 2

`endif
